//--- Bender.yml
package:
  name: conv_3x3_core

sources:
  - source/conv_pkg.sv
  - source/weight_shift_chain.sv
  - source/kernel_fifo.sv
  - source/kernel_mac.sv
  - source/conv_3x3_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/conv_3x3_core_tb.sv

//--- flist.f
+incdir+include
source/conv_pkg.sv
source/weight_shift_chain.sv
source/kernel_fifo.sv
source/kernel_mac.sv
source/conv_3x3_core.sv
test/conv_3x3_core_tb.sv

//--- source/conv_3x3_core.sv
`timescale 1ns/1ps

module conv_3x3_core #(
	parameter int KERNEL_DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              weight_valid,
	input  conv_pkg::data_t   weight_in,
	input  logic              load_weights,
	input  logic              pixel_valid,
	input  conv_pkg::window_t window,
	output logic              weights_ready,
	output logic              kernel_full,
	output logic              result_valid,
	output conv_pkg::acc_t    result
);

	conv_pkg::kernel_t kernel;
	logic              kernel_valid;
	conv_pkg::kernel_t active_kernel;

	//////////////////////////////
	// Weight path
	//////////////////////////////

	weight_shift_chain u_shift_chain (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_in    (weight_in),
		.kernel       (kernel),
		.kernel_valid (kernel_valid)
	);

	kernel_fifo #(
		.KERNEL_DEPTH (KERNEL_DEPTH)
	) u_kernel_fifo (
		.clk           (clk),
		.reset         (reset),
		.kernel        (kernel),
		.kernel_valid  (kernel_valid),
		.load_weights  (load_weights),
		.active_kernel (active_kernel),
		.weights_ready (weights_ready),
		.kernel_full   (kernel_full)
	);

	//////////////////////////////
	// Pixel path
	//////////////////////////////

	kernel_mac u_kernel_mac (
		.clk           (clk),
		.reset         (reset),
		.pixel_valid   (pixel_valid),
		.window        (window),
		.active_kernel (active_kernel),
		.weights_ready (weights_ready),
		.result        (result),
		.result_valid  (result_valid)
	);

endmodule

//--- source/conv_pkg.sv
package conv_pkg;

	//////////////////////////////
	// Data widths
	//////////////////////////////

	// One weight or one pixel
	localparam int DATA_WIDTH = 16;

	// Nine full-range products plus growth, never overflows
	localparam int ACC_WIDTH = 36;

	// Taps of a 3x3 kernel
	localparam int KERNEL_SIZE = 9;

	// Tap counter in the shift chain
	localparam int CNT_WIDTH = 4;

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic signed [DATA_WIDTH-1:0] data_t;

	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	// w00 is the first weight received
	typedef struct packed {
		data_t w00;
		data_t w01;
		data_t w02;
		data_t w03;
		data_t w04;
		data_t w05;
		data_t w06;
		data_t w07;
		data_t w08;
	} kernel_t;

	// Row-major pixel window, p00 top left
	typedef struct packed {
		data_t p00;
		data_t p01;
		data_t p02;
		data_t p10;
		data_t p11;
		data_t p12;
		data_t p20;
		data_t p21;
		data_t p22;
	} window_t;

endpackage

//--- source/kernel_fifo.sv
`timescale 1ns/1ps

module kernel_fifo #(
	parameter int KERNEL_DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  conv_pkg::kernel_t kernel,
	input  logic              kernel_valid,
	input  logic              load_weights,
	output conv_pkg::kernel_t active_kernel,
	output logic              weights_ready,
	output logic              kernel_full
);

	localparam int PTR_WIDTH = $clog2(KERNEL_DEPTH);
	localparam logic [PTR_WIDTH:0] FULL_COUNT = (PTR_WIDTH + 1)'(KERNEL_DEPTH);

	conv_pkg::kernel_t      queue_mem [KERNEL_DEPTH];
	logic [PTR_WIDTH-1:0]   wr_ptr;
	logic [PTR_WIDTH-1:0]   rd_ptr;
	logic [PTR_WIDTH:0]     count;
	logic [PTR_WIDTH:0]     count_next;
	logic                   push;
	logic                   pop;

	// Full queue drops the kernel, empty queue ignores the load
	assign push = kernel_valid && !kernel_full;
	assign pop  = load_weights && (count != '0);

	always_comb begin
		count_next = count;
		case ({push, pop})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	//////////////////////////////
	// Pointers and occupancy
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			kernel_full <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count       <= count_next;
			kernel_full <= (count_next == FULL_COUNT);
		end
	end

	//////////////////////////////
	// Storage and active kernel
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (push)
			queue_mem[wr_ptr] <= kernel;
		if (pop)
			active_kernel <= queue_mem[rd_ptr];
	end

	// Stays set once the first kernel is loaded
	always_ff @(posedge clk) begin
		if (reset)
			weights_ready <= 1'b0;
		else if (pop)
			weights_ready <= 1'b1;
	end

endmodule

//--- source/kernel_mac.sv
`timescale 1ns/1ps

module kernel_mac (
	input  logic              clk,
	input  logic              reset,
	input  logic              pixel_valid,
	input  conv_pkg::window_t window,
	input  conv_pkg::kernel_t active_kernel,
	input  logic              weights_ready,
	output conv_pkg::acc_t    result,
	output logic              result_valid
);

	localparam int PROD_WIDTH = 2 * conv_pkg::DATA_WIDTH;
	localparam int ROWS       = 3;
	localparam int COLS       = 3;

	// Flat views of the window and kernel, element 0 is the last field
	conv_pkg::data_t [conv_pkg::KERNEL_SIZE-1:0] pix_taps;
	conv_pkg::data_t [conv_pkg::KERNEL_SIZE-1:0] kern_taps;

	logic signed [PROD_WIDTH-1:0] prod [conv_pkg::KERNEL_SIZE];
	conv_pkg::acc_t               row_sum [ROWS];
	logic                         prod_valid;
	logic                         row_valid;

	assign pix_taps  = window;
	assign kern_taps = active_kernel;

	//////////////////////////////
	// Stage 1, products
	//////////////////////////////

	always_ff @(posedge clk) begin
		for (int i = 0; i < conv_pkg::KERNEL_SIZE; i++) begin
			prod[i] <= PROD_WIDTH'(pix_taps[i]) * PROD_WIDTH'(kern_taps[i]);
		end
	end

	//////////////////////////////
	// Stage 2, row sums
	//////////////////////////////

	// Three neighbouring flat taps form one window row
	always_ff @(posedge clk) begin
		for (int r = 0; r < ROWS; r++) begin
			row_sum[r] <= conv_pkg::acc_t'(prod[r*COLS])
				+ conv_pkg::acc_t'(prod[r*COLS+1])
				+ conv_pkg::acc_t'(prod[r*COLS+2]);
		end
	end

	//////////////////////////////
	// Stage 3, final sum
	//////////////////////////////

	always_ff @(posedge clk) begin
		result <= row_sum[0] + row_sum[1] + row_sum[2];
	end

	// Valid bits follow each window through the pipe
	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid   <= 1'b0;
			row_valid    <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			// No kernel loaded yet means no result
			prod_valid   <= pixel_valid && weights_ready;
			row_valid    <= prod_valid;
			result_valid <= row_valid;
		end
	end

endmodule

//--- source/weight_shift_chain.sv
`timescale 1ns/1ps

module weight_shift_chain (
	input  logic              clk,
	input  logic              reset,
	input  logic              weight_valid,
	input  conv_pkg::data_t   weight_in,
	output conv_pkg::kernel_t kernel,
	output logic              kernel_valid
);

	// Count value of the ninth weight in a group
	localparam logic [conv_pkg::CNT_WIDTH-1:0] LAST_TAP =
		conv_pkg::CNT_WIDTH'(conv_pkg::KERNEL_SIZE - 1);

	conv_pkg::kernel_t             chain;
	logic [conv_pkg::CNT_WIDTH-1:0] tap_count;

	//////////////////////////////
	// Shift chain
	//////////////////////////////

	// New weights enter at w08 and move toward w00
	always_ff @(posedge clk) begin
		if (weight_valid) begin
			chain.w00 <= chain.w01;
			chain.w01 <= chain.w02;
			chain.w02 <= chain.w03;
			chain.w03 <= chain.w04;
			chain.w04 <= chain.w05;
			chain.w05 <= chain.w06;
			chain.w06 <= chain.w07;
			chain.w07 <= chain.w08;
			chain.w08 <= weight_in;
		end
	end

	//////////////////////////////
	// Tap counter
	//////////////////////////////

	// Counter holds during gaps, wraps after nine weights
	always_ff @(posedge clk) begin
		if (reset) begin
			tap_count    <= '0;
			kernel_valid <= 1'b0;
		end else begin
			kernel_valid <= 1'b0;
			if (weight_valid) begin
				if (tap_count == LAST_TAP) begin
					tap_count    <= '0;
					kernel_valid <= 1'b1;
				end else begin
					tap_count <= tap_count + 1'b1;
				end
			end
		end
	end

	// Full group sits in the chain while kernel_valid is high
	assign kernel = chain;

endmodule

//--- include/conv_tb_table.svh
`ifndef CONV_TB_TABLE_SVH
`define CONV_TB_TABLE_SVH

// One table row, expected is the sum of the nine products
typedef struct {
	string             name;
	conv_pkg::kernel_t kernel;
	conv_pkg::window_t window;
	conv_pkg::acc_t    expected;
} test_entry_t;

localparam int NUM_ENTRIES = 6;

test_entry_t table_entries [NUM_ENTRIES];

task automatic fill_table();
	table_entries[0] = '{"identity", '{0, 0, 0, 0, 1, 0, 0, 0, 0},
		'{1, 2, 3, 4, 5, 6, 7, 8, 9}, 36'sd5};
	table_entries[1] = '{"ones", '{1, 1, 1, 1, 1, 1, 1, 1, 1},
		'{1, 2, 3, 4, 5, 6, 7, 8, 9}, 36'sd45};
	table_entries[2] = '{"neg_mix", '{-1, 2, -3, 4, -5, 6, -7, 8, -9},
		'{10, 10, 10, 10, 10, 10, 10, 10, 10}, -36'sd50};
	// Extreme signed values
	table_entries[3] = '{"max_pos",
		'{32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767},
		'{32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767},
		36'sd9663086601};
	table_entries[4] = '{"min_neg",
		'{-32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768},
		'{-32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768},
		36'sd9663676416};
	table_entries[5] = '{"min_max",
		'{-32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768},
		'{32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767},
		-36'sd9663381504};
endtask

`endif

//--- test/conv_3x3_core_tb.sv
`timescale 1ns/1ps

module conv_3x3_core_tb;

	`include "conv_tb_table.svh"

	localparam int DEPTH = 4;
	localparam int TIMEOUT = 20;

	logic              clk;
	logic              reset;
	logic              weight_valid;
	conv_pkg::data_t   weight_in;
	logic              load_weights;
	logic              pixel_valid;
	conv_pkg::window_t window;
	logic              weights_ready;
	logic              kernel_full;
	logic              result_valid;
	conv_pkg::acc_t    result;

	int                cyc;
	conv_pkg::kernel_t model_q [$];
	conv_pkg::kernel_t model_active;
	logic              model_loaded;
	conv_pkg::kernel_t rand_k [5];
	// Batch of windows applied on consecutive cycles
	conv_pkg::window_t win_q [$];
	conv_pkg::acc_t    exp_q [$];
	string             name_q [$];
	logic              load_q [$];
	int                issue_q [$];

	conv_3x3_core #(
		.KERNEL_DEPTH (DEPTH)
	) UUT (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.weight_in     (weight_in),
		.load_weights  (load_weights),
		.pixel_valid   (pixel_valid),
		.window        (window),
		.weights_ready (weights_ready),
		.kernel_full   (kernel_full),
		.result_valid  (result_valid),
		.result        (result)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic fail_now(string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_result(string name, conv_pkg::acc_t expected, conv_pkg::acc_t actual);
		if (actual !== expected)
			fail_now($sformatf("ERR %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic check_kernel(string name, conv_pkg::kernel_t expected,
		conv_pkg::kernel_t actual);
		if (actual !== expected)
			fail_now($sformatf("ERR %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_flag(string name, logic expected, logic actual);
		if (actual !== expected)
			fail_now($sformatf("ERR %s expected %b actual %b", name, expected, actual));
	endtask

	task automatic check_latency(string name, int expected, int actual);
		if (actual != expected)
			fail_now($sformatf("ERR %s latency expected %0d actual %0d", name, expected, actual));
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic conv_pkg::acc_t dot_product(conv_pkg::kernel_t k, conv_pkg::window_t w);
		conv_pkg::acc_t sum;
		sum = conv_pkg::acc_t'(k.w00) * conv_pkg::acc_t'(w.p00);
		sum += conv_pkg::acc_t'(k.w01) * conv_pkg::acc_t'(w.p01);
		sum += conv_pkg::acc_t'(k.w02) * conv_pkg::acc_t'(w.p02);
		sum += conv_pkg::acc_t'(k.w03) * conv_pkg::acc_t'(w.p10);
		sum += conv_pkg::acc_t'(k.w04) * conv_pkg::acc_t'(w.p11);
		sum += conv_pkg::acc_t'(k.w05) * conv_pkg::acc_t'(w.p12);
		sum += conv_pkg::acc_t'(k.w06) * conv_pkg::acc_t'(w.p20);
		sum += conv_pkg::acc_t'(k.w07) * conv_pkg::acc_t'(w.p21);
		sum += conv_pkg::acc_t'(k.w08) * conv_pkg::acc_t'(w.p22);
		return sum;
	endfunction

	function automatic logic [16*9-1:0] random_taps();
		logic [16*9-1:0] bits;
		bits = '0;
		for (int i = 0; i < 9; i++)
			bits = {bits[16*8-1:0], 16'($urandom)};
		return bits;
	endfunction

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// Sends w00 first, with random gaps, then mirrors the push or drop
	task automatic stream_kernel(conv_pkg::kernel_t k);
		conv_pkg::data_t [8:0] taps;
		taps = k;
		for (int i = 8; i >= 0; i--) begin
			@(posedge clk);
			weight_valid <= 1'b1;
			weight_in    <= taps[i];
			@(posedge clk);
			weight_valid <= 1'b0;
			repeat ($urandom % 3) @(posedge clk);
		end
		repeat (3) @(posedge clk);
		if (model_q.size() < DEPTH)
			model_q.push_back(k);
	endtask

	// Active kernel is unknown until the first real load
	task automatic pulse_load();
		@(posedge clk);
		load_weights <= 1'b1;
		@(posedge clk);
		load_weights <= 1'b0;
		if (model_q.size() > 0) begin
			model_active = model_q.pop_front();
			model_loaded = 1'b1;
		end
		@(posedge clk);
		if (model_loaded)
			check_kernel("active_kernel", model_active, UUT.u_kernel_fifo.active_kernel);
	endtask

	task automatic add_window(string name, conv_pkg::window_t w, conv_pkg::acc_t e, logic ld);
		name_q.push_back(name);
		win_q.push_back(w);
		exp_q.push_back(e);
		load_q.push_back(ld);
	endtask

	// Drives the batch back to back while a second branch collects results
	task automatic run_batch();
		int n;
		n = win_q.size();
		issue_q.delete();
		fork
			begin
				for (int i = 0; i < n; i++) begin
					@(posedge clk);
					pixel_valid  <= 1'b1;
					window       <= win_q[i];
					load_weights <= load_q[i];
					issue_q.push_back(cyc + 1);
				end
				@(posedge clk);
				pixel_valid  <= 1'b0;
				load_weights <= 1'b0;
			end
			begin
				for (int i = 0; i < n; i++) begin
					int t;
					t = 0;
					do begin
						@(negedge clk);
						t++;
					end while (!result_valid && t < TIMEOUT);
					if (!result_valid)
						fail_now($sformatf("timed out waiting for the result of %s", name_q[i]));
					check_result(name_q[i], exp_q[i], result);
					check_latency(name_q[i], 3, cyc - issue_q[i]);
				end
			end
		join
		name_q.delete();
		win_q.delete();
		exp_q.delete();
		load_q.delete();
		repeat (2) @(posedge clk);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int t;
		void'($urandom(32'h2feb));
		cyc          = 0;
		reset        = 1'b1;
		weight_valid = 1'b0;
		weight_in    = '0;
		load_weights = 1'b0;
		pixel_valid  = 1'b0;
		window       = '0;
		model_active = '0;
		model_loaded = 1'b0;
		fill_table();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		// Reset state
		check_flag("reset weights_ready", 1'b0, weights_ready);
		check_flag("reset kernel_full", 1'b0, kernel_full);
		check_flag("reset result_valid", 1'b0, result_valid);
		@(posedge clk);
		pixel_valid <= 1'b1;
		window      <= table_entries[0].window;
		@(posedge clk);
		pixel_valid <= 1'b0;
		t = 0;
		while (t < 10) begin
			@(negedge clk);
			if (result_valid)
				fail_now("result_valid rose with no kernel loaded");
			t++;
		end
		pulse_load();
		check_flag("empty load weights_ready", 1'b0, weights_ready);

		// Single kernel
		stream_kernel(table_entries[0].kernel);
		pulse_load();
		check_flag("weights_ready after load", 1'b1, weights_ready);
		add_window(table_entries[0].name, table_entries[0].window,
			table_entries[0].expected, 1'b0);
		run_batch();

		// Queued kernels in arrival order
		for (int i = 1; i <= 3; i++)
			stream_kernel(table_entries[i].kernel);
		for (int i = 1; i <= 3; i++) begin
			pulse_load();
			add_window(table_entries[i].name, table_entries[i].window,
				table_entries[i].expected, 1'b0);
			run_batch();
		end

		// Full queue drops the fifth kernel
		for (int i = 0; i < 5; i++) begin
			rand_k[i] = conv_pkg::kernel_t'(random_taps());
			stream_kernel(rand_k[i]);
			@(negedge clk);
			check_flag($sformatf("kernel_full after kernel %0d", i + 1), i >= 3, kernel_full);
		end
		for (int i = 0; i < 4; i++) begin
			pulse_load();
			check_kernel($sformatf("queued kernel %0d", i + 1), rand_k[i],
				UUT.u_kernel_fifo.active_kernel);
			add_window($sformatf("queued_%0d", i + 1), table_entries[1].window,
				dot_product(model_active, table_entries[1].window), 1'b0);
			run_batch();
		end
		check_flag("kernel_full after pops", 1'b0, kernel_full);
		pulse_load();
		check_kernel("fifth load keeps kernel 4", rand_k[3], UUT.u_kernel_fifo.active_kernel);

		// Back-to-back windows with extreme values
		stream_kernel(table_entries[4].kernel);
		pulse_load();
		add_window(table_entries[4].name, table_entries[4].window,
			table_entries[4].expected, 1'b0);
		add_window(table_entries[5].name, table_entries[5].window,
			table_entries[5].expected, 1'b0);
		for (int i = 0; i < 4; i++) begin
			conv_pkg::window_t w;
			w = conv_pkg::window_t'(random_taps());
			add_window($sformatf("random_%0d", i), w, dot_product(model_active, w), 1'b0);
		end
		run_batch();

		// Load between two consecutive windows
		rand_k[0] = conv_pkg::kernel_t'(random_taps());
		stream_kernel(rand_k[0]);
		add_window("old_kernel", table_entries[2].window,
			dot_product(model_active, table_entries[2].window), 1'b1);
		add_window("new_kernel", table_entries[2].window,
			dot_product(rand_k[0], table_entries[2].window), 1'b0);
		model_active = model_q.pop_front();
		run_batch();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
